// File: src/synth_pkg.sv
`default_nettype none

package synth_pkg;

	// Timing and table geometry
	localparam logic [15:0] SAMPLE_RATE = 16'd48000;	// Phase wraps here, 32 steps per table entry
	localparam logic [15:0] SAMPLE_INTERVAL = 16'd1500;	// System clocks per output sample
	localparam int LUT_SIZE = 1500;
	localparam int POS_SHIFT = 5;				// Phase position to 11 bit table address
	localparam int MAX_HARMONICS = 8;

	// Output side
	localparam logic [7:0] DAC_CHANNEL_A = 8'h31;		// Write and update channel A
	localparam logic [31:0] ACC_OFFSET = 32'h1FFFF;		// Midscale after the final divide by four
	localparam logic [15:0] DEFAULT_FREQUENCY = 16'd1000;
	localparam int DAC_CLOCK_DIV = 4;			// System clocks per DAC bit

	// Opcodes carried in the top byte of a control word
	typedef enum logic [7:0] {
		op_set_frequency = 8'd1,
		op_set_harmonics = 8'd2,
		op_restart_phase = 8'd3
	} adc_op_e;

	typedef enum logic [1:0] {
		st_idle,
		st_init,
		st_calc,
		st_done
	} engine_state_e;

	// One received SPI frame, MSB first on the wire
	typedef struct packed {
		adc_op_e op;
		logic [15:0] value;
	} adc_word_t;

	typedef struct packed {
		logic [15:0] frequency;
		logic [3:0] harmonic_count;	// Always 1 to MAX_HARMONICS
		logic restart;			// Single cycle pulse
	} synth_config_t;

	// Frame sent to the DAC
	typedef struct packed {
		logic [7:0] command;
		logic [15:0] sample;
	} dac_word_t;

endpackage

`default_nettype wire

// File: src/adc_spi_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module adc_spi_receiver (
	input wire adc_data_received,
	input wire reset,
	input wire spi_nss,
	input wire spi_clock,
	input wire spi_data,
	output synth_pkg::adc_word_t word,
	output logic word_valid
);

	// Two sync flops plus one history flop for edge detection
	logic [2:0] nss_sync;
	logic [2:0] clk_sync;
	logic [1:0] data_sync;

	logic [23:0] shift_q;	// Incoming bits, newest in bit 0
	logic [4:0] bit_count;	// Saturates so long frames never alias to 24

	logic sclk_rise;
	logic nss_rise;
	logic nss_low;

	assign sclk_rise = clk_sync[1] & ~clk_sync[2];
	assign nss_rise = nss_sync[1] & ~nss_sync[2];
	assign nss_low = ~nss_sync[1];

	always_ff @(posedge adc_data_received or posedge reset) begin
		if (reset) begin
			nss_sync <= 3'b111;	// Bus idles deselected
			clk_sync <= 3'b000;
			data_sync <= 2'b00;
			bit_count <= 5'd0;
			word_valid <= 1'b0;
		end else begin
			nss_sync <= {nss_sync[1:0], spi_nss};
			clk_sync <= {clk_sync[1:0], spi_clock};
			data_sync <= {data_sync[0], spi_data};
			word_valid <= 1'b0;

			if (nss_rise) begin
				word_valid <= (bit_count == 5'd24);	// Anything else is dropped
				bit_count <= 5'd0;
			end else if (nss_low && sclk_rise && bit_count != 5'd31) begin
				bit_count <= bit_count + 5'd1;
			end
		end
	end

	// Data path, aligned with the synchronized clock
	always_ff @(posedge adc_data_received) begin
		if (nss_low && sclk_rise) begin
			shift_q <= {shift_q[22:0], data_sync[1]};
		end
		if (nss_rise) begin
			word <= shift_q;	// Only used when word_valid fires
		end
	end

endmodule

`default_nettype wire

// File: src/synth_config.sv
`timescale 1ns/1ps
`default_nettype none

module synth_config (
	input wire adc_data_received,
	input wire reset,
	input wire synth_pkg::adc_word_t word,
	input wire word_valid,
	output synth_pkg::synth_config_t cfg,
	output logic err_out
);

	import synth_pkg::*;

	// Harmonic count limited to 1..MAX_HARMONICS
	function automatic logic [3:0] clamp_count(input logic [15:0] requested);
		if (requested == 16'd0) begin
			return 4'd1;
		end else if (requested > 16'(MAX_HARMONICS)) begin
			return 4'(MAX_HARMONICS);
		end
		return requested[3:0];
	endfunction

	always_ff @(posedge adc_data_received or posedge reset) begin
		if (reset) begin
			cfg.frequency <= DEFAULT_FREQUENCY;
			cfg.harmonic_count <= 4'd1;	// Fundamental only
			cfg.restart <= 1'b0;
			err_out <= 1'b0;
		end else begin
			cfg.restart <= 1'b0;	// Pulse, cleared every cycle

			if (word_valid) begin
				case (word.op)
					op_set_frequency: begin
						cfg.frequency <= word.value;
					end
					op_set_harmonics: begin
						cfg.harmonic_count <= clamp_count(word.value);
					end
					op_restart_phase: begin
						cfg.restart <= 1'b1;
					end
					default: begin
						// Unknown opcode, sticky until reset
						err_out <= 1'b1;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: src/sine_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sine_rom (
	input wire adc_data_received,
	input wire reset,
	input wire [10:0] addr,
	output logic signed [15:0] value
);

	import synth_pkg::*;

	// One full sine period across the table
	logic signed [15:0] table_mem [LUT_SIZE];

	logic [10:0] addr_q;	// First stage, registered address

	initial begin
		real angle;
		for (int k = 0; k < LUT_SIZE; k++) begin
			angle = 6.283185307179586 * k / LUT_SIZE;	// Two pi times k / size
			table_mem[k] = 16'(int'(32767.0 * $sin(angle)));	// Cast rounds to nearest
		end
	end

	// Address in cycle t, value visible in cycle t+2
	always_ff @(posedge adc_data_received or posedge reset) begin
		if (reset) begin
			addr_q <= 11'd0;
			value <= 16'sd0;
		end else begin
			addr_q <= addr;
			value <= table_mem[addr_q];	// Second stage, output register
		end
	end

endmodule

`default_nettype wire

// File: src/phase_ram.sv
`timescale 1ns/1ps
`default_nettype none

module phase_ram (
	input wire adc_data_received,
	input wire [2:0] addr,
	input wire write,
	input wire [15:0] write_data,
	output logic [15:0] read_data
);

	import synth_pkg::*;

	// One phase position per harmonic, contents undefined until written
	logic [15:0] mem [MAX_HARMONICS];

	always_ff @(posedge adc_data_received) begin
		if (write) begin
			mem[addr] <= write_data;
		end
		read_data <= mem[addr];	// Old data on a same address write
	end

endmodule

`default_nettype wire

// File: src/harmonic_engine.sv
`timescale 1ns/1ps
`default_nettype none

module harmonic_engine (
	input wire adc_data_received,
	input wire reset,
	input wire synth_pkg::synth_config_t cfg,
	output logic send,
	output synth_pkg::dac_word_t dac_word
);

	import synth_pkg::*;

	engine_state_e state;
	logic [15:0] sample_timer;
	logic [2:0] step;		// Five steps per harmonic, 0 to 4
	logic [2:0] harm;		// Harmonic index, 0 is the fundamental
	logic [3:0] count_q;		// Harmonic count for this mix
	logic [15:0] freq_q;		// Frequency for this mix
	logic [19:0] inc;		// (harm + 1) * frequency, up to 8 * 65535
	logic [MAX_HARMONICS-1:0] phase_valid;	// Cleared means the RAM entry reads as zero
	logic signed [31:0] acc;

	logic [15:0] phase_q;		// Stepped phase of the current harmonic
	logic [15:0] ram_rdata;
	logic [15:0] stored_phase;
	logic [15:0] next_phase;
	logic ram_write;
	logic [10:0] rom_addr;
	logic signed [15:0] rom_value;
	logic signed [15:0] weighted;

	assign stored_phase = phase_valid[harm] ? ram_rdata : 16'd0;
	assign next_phase = 16'((20'(stored_phase) + inc) % 20'(SAMPLE_RATE));
	assign ram_write = (state == st_calc) && (step == 3'd2);
	assign rom_addr = 11'(phase_q >> POS_SHIFT);	// Max 47999 >> 5 = 1499
	assign weighted = (harm == 3'd0) ? rom_value : (rom_value >>> 1);	// Overtones at half level

	phase_ram u_phase_ram (
		.adc_data_received(adc_data_received),
		.addr(harm),
		.write(ram_write),
		.write_data(phase_q),
		.read_data(ram_rdata)
	);

	sine_rom u_sine_rom (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.addr(rom_addr),
		.value(rom_value)
	);

	always_ff @(posedge adc_data_received or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			sample_timer <= 16'd0;
			step <= 3'd0;
			harm <= 3'd0;
			count_q <= 4'd1;
			freq_q <= DEFAULT_FREQUENCY;
			inc <= 20'd0;
			phase_valid <= '0;	// All phases read as zero
			acc <= ACC_OFFSET;	// First frame is midscale
			send <= 1'b0;
		end else if (cfg.restart) begin
			// Same state as after reset
			state <= st_idle;
			sample_timer <= 16'd0;
			step <= 3'd0;
			harm <= 3'd0;
			phase_valid <= '0;
			acc <= ACC_OFFSET;
			send <= 1'b0;
		end else begin
			send <= 1'b0;

			if (sample_timer == SAMPLE_INTERVAL) begin
				sample_timer <= 16'd0;
				send <= 1'b1;	// dac_word captured in the same cycle
				state <= st_init;
			end else begin
				sample_timer <= sample_timer + 16'd1;

				case (state)
					st_idle: ;	// Wait for the next sample slot
					st_init: begin
						freq_q <= cfg.frequency;
						count_q <= cfg.harmonic_count;
						inc <= 20'(cfg.frequency);	// Fundamental steps by f
						acc <= ACC_OFFSET;
						harm <= 3'd0;
						step <= 3'd0;
						state <= st_calc;
					end
					st_calc: begin
						step <= step + 3'd1;
						case (step)
							3'd2: begin
								// Phase written back, table address presented
								phase_valid[harm] <= 1'b1;
								inc <= inc + 20'(freq_q);
							end
							3'd4: begin
								acc <= acc + weighted;	// Table value arrived
								step <= 3'd0;
								if ({1'b0, harm} + 4'd1 == count_q) begin
									state <= st_done;
								end else begin
									harm <= harm + 3'd1;
								end
							end
							default: ;	// RAM or table read in flight
						endcase
					end
					st_done: begin
						state <= st_idle;
					end
				endcase
			end
		end
	end

	// Payload registers
	always_ff @(posedge adc_data_received) begin
		if (state == st_calc && step == 3'd1) begin
			phase_q <= next_phase;	// Stored phase plus increment, wrapped
		end
		if (sample_timer == SAMPLE_INTERVAL) begin
			dac_word.command <= DAC_CHANNEL_A;
			dac_word.sample <= acc[17:2];	// Divide by four, headroom for the mix
		end
	end

endmodule

`default_nettype wire

// File: src/dac_spi_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module dac_spi_transmitter (
	input wire adc_data_received,
	input wire reset,
	input wire synth_pkg::dac_word_t data,
	input wire send,
	output logic spi_cs,
	output logic spi_clock,
	output logic spi_data
);

	import synth_pkg::*;

	logic cs_q;				// Low while a frame is in progress
	logic [$clog2(DAC_CLOCK_DIV)-1:0] div_q;	// Position inside one bit
	logic [4:0] bit_q;			// Bit index, 0 to 23
	logic [23:0] shift_q;			// MSB is on the wire
	logic bit_end;

	assign bit_end = (div_q == DAC_CLOCK_DIV - 1);

	assign spi_cs = cs_q;
	// Low for the first half of each bit, rising mid-bit
	assign spi_clock = ~cs_q & (div_q >= DAC_CLOCK_DIV / 2);
	assign spi_data = ~cs_q & shift_q[23];	// Idle low between frames

	always_ff @(posedge adc_data_received or posedge reset) begin
		if (reset) begin
			cs_q <= 1'b1;
			div_q <= '0;
			bit_q <= 5'd0;
		end else if (cs_q) begin
			if (send) begin
				cs_q <= 1'b0;	// Frame starts next cycle
				div_q <= '0;
				bit_q <= 5'd0;
			end
		end else begin
			// Busy, a send here is ignored
			div_q <= div_q + 1'b1;
			if (bit_end) begin
				div_q <= '0;
				if (bit_q == 5'd23) begin
					cs_q <= 1'b1;	// Last bit done
				end else begin
					bit_q <= bit_q + 5'd1;
				end
			end
		end
	end

	// Shift register, loaded on send and advanced at each bit boundary
	always_ff @(posedge adc_data_received) begin
		if (cs_q && send) begin
			shift_q <= data;
		end else if (!cs_q && bit_end) begin
			shift_q <= {shift_q[22:0], 1'b0};	// Next bit while clock goes low
		end
	end

endmodule

`default_nettype wire

// File: src/synth_top.sv
`timescale 1ns/1ps
`default_nettype none

module synth_top (
	input wire adc_data_received,
	input wire reset,
	input wire adc_spi_nss,
	input wire adc_spi_clock,
	input wire adc_spi_data,
	output logic dac_spi_cs,
	output logic dac_spi_clock,
	output logic dac_spi_data,
	output logic err_out
);

	import synth_pkg::*;

	adc_word_t word;
	logic word_valid;
	synth_config_t cfg;
	logic send;
	dac_word_t dac_word;

	// Control words from the converter board
	adc_spi_receiver u_receiver (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.spi_nss(adc_spi_nss),
		.spi_clock(adc_spi_clock),
		.spi_data(adc_spi_data),
		.word(word),
		.word_valid(word_valid)
	);

	synth_config u_config (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.word(word),
		.word_valid(word_valid),
		.cfg(cfg),
		.err_out(err_out)
	);

	harmonic_engine u_engine (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.cfg(cfg),
		.send(send),
		.dac_word(dac_word)
	);

	// One frame per sample to the DAC
	dac_spi_transmitter u_dac (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.data(dac_word),
		.send(send),
		.spi_cs(dac_spi_cs),
		.spi_clock(dac_spi_clock),
		.spi_data(dac_spi_data)
	);

endmodule

`default_nettype wire

// File: verification/synth_tb.sv
`timescale 1ns/1ps
`default_nettype none

module synth_tb;

	import synth_pkg::*;

	localparam int FRAME_TIMEOUT = 2 * SAMPLE_INTERVAL + 200;	// Cycles allowed per frame

	logic adc_data_received = 1'b0;
	logic reset;
	logic adc_spi_nss;
	logic adc_spi_clock;
	logic adc_spi_data;
	wire dac_spi_cs;
	wire dac_spi_clock;
	wire dac_spi_data;
	wire err_out;

	int cycle;
	int total_errors;
	int test_errors;
	int format_errors;
	int tests_run;
	int tests_failed;
	int lcg_state;

	// DAC frame capture
	logic [23:0] frames[$];		// Oldest first
	logic [23:0] shift_in;
	int bit_total;
	int fall_cycle;
	int last_fall = -1;		// No spacing reference yet
	logic frame_open = 1'b0;

	// Reference model state
	int sine_ref [1500];
	int phase [1:8];		// Indexed by harmonic number
	int model_freq;
	int model_count;

	synth_top dut0 (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.adc_spi_nss(adc_spi_nss),
		.adc_spi_clock(adc_spi_clock),
		.adc_spi_data(adc_spi_data),
		.dac_spi_cs(dac_spi_cs),
		.dac_spi_clock(dac_spi_clock),
		.dac_spi_data(dac_spi_data),
		.err_out(err_out)
	);

	always #20 adc_data_received = ~adc_data_received;

	always @(posedge adc_data_received) cycle = cycle + 1;

	// Idle outputs while reset is held
	always @(negedge adc_data_received) begin
		if (reset) begin
			assert (dac_spi_cs === 1'b1 && dac_spi_clock === 1'b0 && dac_spi_data === 1'b0
				&& err_out === 1'b0) else begin
				$display("Outputs not idle during reset at cycle %0d", cycle);
				test_errors++;
				total_errors++;
			end
		end
	end

	always @(negedge dac_spi_cs) begin
		frame_open = 1'b1;
		bit_total = 0;
		fall_cycle = cycle;
		if (last_fall >= 0) begin
			assert (fall_cycle - last_fall == SAMPLE_INTERVAL + 1) else begin
				$display("FAIL frame_format expected spacing %0d actual %0d",
					SAMPLE_INTERVAL + 1, fall_cycle - last_fall);
				format_errors++;
				total_errors++;
			end
		end
		last_fall = fall_cycle;
	end

	always @(posedge dac_spi_clock) begin
		if (dac_spi_cs === 1'b0) begin
			shift_in = {shift_in[22:0], dac_spi_data};	// MSB first
			bit_total++;
		end
	end

	always @(posedge dac_spi_cs) begin
		if (frame_open) begin
			frame_open = 1'b0;
			assert (bit_total == 24 && cycle - fall_cycle == 24 * DAC_CLOCK_DIV) else begin
				$display("FAIL frame_format expected 24 bits in %0d cycles actual %0d in %0d",
					24 * DAC_CLOCK_DIV, bit_total, cycle - fall_cycle);
				format_errors++;
				total_errors++;
			end
			frames.push_back(shift_in);
		end
	end

	function automatic int lcg_next();
		lcg_state = (lcg_state * 1103515245 + 12345) & 32'h7FFFFFFF;
		return lcg_state;
	endfunction

	function automatic int clamp_harmonics(input int requested);
		if (requested < 1) begin
			return 1;
		end
		return (requested > 8) ? 8 : requested;
	endfunction

	function automatic void model_restart(input int freq, input int count);
		model_freq = freq;
		model_count = count;
		for (int h = 1; h <= 8; h++) begin
			phase[h] = 0;
		end
	endfunction

	// One sample step, overtones at half level, sum on the midscale offset
	function automatic logic [15:0] model_step();
		int acc;
		acc = 32'h1FFFF;
		for (int h = 1; h <= model_count; h++) begin
			phase[h] = (phase[h] + h * model_freq) % 48000;
			if (h == 1) begin
				acc += sine_ref[phase[h] >> 5];
			end else begin
				acc += sine_ref[phase[h] >> 5] >>> 1;
			end
		end
		return acc[17:2];
	endfunction

	task automatic abort_run(input string why);
		$display("Timeout: %s", why);
		$display("Some tests failed");
		$finish;
	endtask

	// Bit-banged control word, SPI clock at one eighth of the system clock
	task automatic spi_write(input logic [23:0] word, input int nbits);
		@(negedge adc_data_received);
		adc_spi_nss = 1'b0;
		for (int i = nbits - 1; i >= 0; i--) begin
			adc_spi_clock = 1'b0;
			adc_spi_data = word[i];
			repeat (4) @(negedge adc_data_received);
			adc_spi_clock = 1'b1;	// Receiver samples here
			repeat (4) @(negedge adc_data_received);
		end
		adc_spi_clock = 1'b0;
		repeat (4) @(negedge adc_data_received);
		adc_spi_nss = 1'b1;
		adc_spi_data = 1'b0;
		repeat (8) @(negedge adc_data_received);	// Word decoded and applied by now
	endtask

	task automatic get_frame(output logic [23:0] frame);
		int waited;
		waited = 0;
		while (frames.size() == 0) begin
			if (waited == FRAME_TIMEOUT) begin
				abort_run("no DAC frame arrived");
			end
			@(negedge adc_data_received);
			waited++;
		end
		frame = frames.pop_front();
	endtask

	task automatic compare_frame(input string name, input logic [23:0] expected);
		logic [23:0] actual;
		get_frame(actual);
		assert (actual === expected) else begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic expect_model_frames(input string name, input int count);
		for (int i = 0; i < count; i++) begin
			compare_frame(name, {8'h31, model_step()});
		end
	endtask

	task automatic report_test(input string name, input int errors);
		tests_run++;
		if (errors != 0) begin
			tests_failed++;
		end
		$display("Test %s finished with %0d errors", name, errors);
		test_errors = 0;
	endtask

	initial begin
		int freq;
		int req;
		int waited;
		reset = 1'b1;
		adc_spi_nss = 1'b1;
		adc_spi_clock = 1'b0;
		adc_spi_data = 1'b0;
		cycle = 0;
		total_errors = 0;
		test_errors = 0;
		format_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		lcg_state = 66985;
		for (int k = 0; k < 1500; k++) begin
			sine_ref[k] = $rtoi($floor(32767.0 * $sin(2.0 * 3.141592653589793 * k / 1500.0)
				+ 0.5));
		end
		repeat (4) @(posedge adc_data_received);
		@(negedge adc_data_received);
		reset = 1'b0;

		model_restart(1000, 1);
		compare_frame("reset_state", 24'h317FFF);	// Midscale first
		report_test("reset_state", test_errors);

		expect_model_frames("default_tone", 5);
		report_test("default_tone", test_errors);

		for (int i = 0; i < 4; i++) begin
			freq = lcg_next() % 48000;
			req = (i == 3) ? 9 + lcg_next() % 4 : lcg_next() % 9;	// Last pass hits the clamp
			spi_write({op_set_frequency, freq[15:0]}, 24);
			spi_write({op_set_harmonics, req[15:0]}, 24);
			spi_write({op_restart_phase, 16'h0000}, 24);
			waited = 0;
			while (dac_spi_cs !== 1'b1) begin
				if (waited == 200) begin
					abort_run("DAC chip select stuck low after restart");
				end
				@(negedge adc_data_received);
				waited++;
			end
			frames.delete();	// Drop frames from before the restart
			last_fall = -1;
			model_restart(freq, clamp_harmonics(req));
			compare_frame("random_config", 24'h317FFF);
			expect_model_frames("random_config", 4);
		end
		report_test("random_config", test_errors);

		spi_write(24'h012345, 20);	// Truncated frame
		assert (err_out === 1'b0) else begin
			$display("err_out rose after a truncated frame");
			test_errors++;
			total_errors++;
		end
		expect_model_frames("unknown_opcode", 2);
		spi_write({8'hA5, 16'h1234}, 24);
		waited = 0;
		while (err_out !== 1'b1) begin
			if (waited == 100) begin
				abort_run("err_out did not rise after an unknown opcode");
			end
			@(negedge adc_data_received);
			waited++;
		end
		expect_model_frames("unknown_opcode", 3);
		report_test("unknown_opcode", test_errors);
		report_test("frame_format", format_errors);

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
src/synth_pkg.sv
src/adc_spi_receiver.sv
src/synth_config.sv
src/sine_rom.sv
src/phase_ram.sv
src/harmonic_engine.sv
src/dac_spi_transmitter.sv
src/synth_top.sv
verification/synth_tb.sv
